/* verilog/pollable_memory_defs.svh */
/* sizes shared by the pollable memory design
   the playback region must lie inside the byte address space */

`ifndef POLLABLE_MEMORY_DEFS_SVH
`define POLLABLE_MEMORY_DEFS_SVH

// host bus
`define BUS_WIDTH           16
`define HALFWORDS_PER_WORD  2   // transactions per data word

// memory
`define ADDRESS_DEPTH       8   // 256 words of 32 bits
`define BYTE_ADDRESS_DEPTH  (`ADDRESS_DEPTH + 2)

// pipeline depths
`define SYNC_STAGES         3   // input synchronizer
`define ACK_STAGES          4   // delay from internal ack to ack_valid

// playback region, in bytes
`define PLAYBACK_START      0
`define PLAYBACK_BYTES      32

`define ERROR_COUNT_WIDTH   8   // counters wrap

`endif

/* verilog/bus_pkg.sv */
/* types for the host side of the parallel bus
   one bus sample, the settled levels and the error counters */

`include "pollable_memory_defs.svh"

package bus_pkg;

	// one sample of the raw host lines
	typedef struct packed {
		logic                  enable;          // 1 = active
		logic                  read;            // 1 = read, 0 = write
		logic                  register_select; // 1 = data, 0 = address
		logic [`BUS_WIDTH-1:0] data;
	} bus_cmd_t;

	// levels seen stable after the synchronizer
	typedef struct packed {
		logic active;
		logic idle;
		logic read_mode;
		logic write_mode_data;
		logic write_mode_address;
	} bus_settled_t;

	// abandoned partial transfers
	typedef struct packed {
		logic [`ERROR_COUNT_WIDTH-1:0] read_errors;
		logic [`ERROR_COUNT_WIDTH-1:0] write_errors;
		logic [`ERROR_COUNT_WIDTH-1:0] address_errors;
	} error_counts_t;

endpackage

/* verilog/mem_pkg.sv */
/* types for the word memory and the byte playback port
   halfword 1 and byte 3 are the most significant */

`include "pollable_memory_defs.svh"

package mem_pkg;

	// bus side sees halfwords, the gearbox sees bytes
	typedef union packed {
		logic [`HALFWORDS_PER_WORD-1:0][`BUS_WIDTH-1:0] halfwords;
		logic [3:0][7:0]                                bytes;
	} data_word_t;

	// port a request
	typedef struct packed {
		logic [`ADDRESS_DEPTH-1:0] address;
		data_word_t                data;
		logic                      write_strobe; // one cycle per word
	} mem_write_t;

	// playback stream, one byte per clock
	typedef struct packed {
		logic [7:0] data_byte;
		logic       sync; // first byte of the region
	} playback_t;

endpackage

/* verilog/bus_sync.sv */
/* host lines are asynchronous to clock
   a level counts only when the last two stages agree */

`include "pollable_memory_defs.svh"

module bus_sync (
	input  logic                    clock,
	input  logic                    reset125,
	input  bus_pkg::bus_cmd_t       cmd,
	output bus_pkg::bus_settled_t   settled,
	output logic [`BUS_WIDTH-1:0]   bus_data
);
	import bus_pkg::*;

	localparam int LAST = `SYNC_STAGES - 1;

	bus_cmd_t stage [`SYNC_STAGES];

	logic enable_high;
	logic enable_low;
	logic read_high;
	logic read_low;
	logic select_high;
	logic select_low;

	// agreement of the two oldest stages
	assign enable_high = stage[LAST].enable & stage[LAST-1].enable;
	assign enable_low  = ~(stage[LAST].enable | stage[LAST-1].enable);
	assign read_high   = stage[LAST].read & stage[LAST-1].read;
	assign read_low    = ~(stage[LAST].read | stage[LAST-1].read);
	assign select_high = stage[LAST].register_select & stage[LAST-1].register_select;
	assign select_low  = ~(stage[LAST].register_select | stage[LAST-1].register_select);

	always_ff @(posedge clock) begin
		if (reset125) begin
			for (int i = 0; i < `SYNC_STAGES; i++) begin
				stage[i] <= '0;
			end
			settled <= '0;
		end else begin
			stage[0] <= cmd;
			for (int i = 1; i < `SYNC_STAGES; i++) begin
				stage[i] <= stage[i-1];
			end
			settled.active             <= enable_high;
			settled.idle               <= enable_low;
			settled.read_mode          <= read_high;
			settled.write_mode_data    <= read_low & select_high;
			settled.write_mode_address <= read_low & select_low; // select 0 means address
		end
	end

	// lines up with settled
	always_ff @(posedge clock) begin
		bus_data <= stage[LAST].data;
	end

endmodule

/* verilog/bus_slave.sv */
/* host must hold a transaction until ack_valid and keep enable low long enough
   for the idle sequencing; one address transaction, two per data word */

`include "pollable_memory_defs.svh"

module bus_slave (
	input  logic                     clock,
	input  logic                     reset125,
	input  bus_pkg::bus_settled_t    settled,
	input  logic [`BUS_WIDTH-1:0]    bus_data,
	input  mem_pkg::data_word_t      read_word,
	output mem_pkg::mem_write_t      mem_write,
	output logic [`BUS_WIDTH-1:0]    bus_out,
	output logic                     ack_valid,
	output bus_pkg::error_counts_t   errors
);
	import mem_pkg::*;

	localparam int HW_BITS = $clog2(`HALFWORDS_PER_WORD);
	localparam logic [HW_BITS-1:0] LAST_HW = HW_BITS'(`HALFWORDS_PER_WORD - 1);

	// state bit 0 marks a captured halfword, bit 1 a finished word
	logic [1:0]                astate;
	logic [1:0]                wstate;
	logic [1:0]                rstate;
	logic [HW_BITS-1:0]        wword; // counts down from the msb halfword
	logic [HW_BITS-1:0]        rword;
	logic [`ADDRESS_DEPTH-1:0] address_word;
	logic [`ADDRESS_DEPTH-1:0] address_reg;
	data_word_t                write_data;
	logic                      write_strobe;
	logic                      pre_ack;
	logic [`ACK_STAGES-1:0]    ack_pipe;

	logic write_partial;
	logic read_partial;
	logic address_partial;

	assign write_partial   = (wstate != 2'b00) || (wword != LAST_HW);
	assign read_partial    = (rstate != 2'b00) || (rword != LAST_HW);
	assign address_partial = (astate != 2'b00);

	// ------------------------------
	// halfword capture
	always_ff @(posedge clock) begin
		if (settled.active && settled.write_mode_data && wstate == 2'b00) begin
			write_data.halfwords[wword] <= bus_data;
		end
		if (settled.active && settled.write_mode_address && astate == 2'b00) begin
			address_word <= bus_data[`ADDRESS_DEPTH-1:0];
		end
		if (settled.active && settled.read_mode && rstate == 2'b00) begin
			bus_out <= read_word.halfwords[rword];
		end
	end

	// ------------------------------
	// sequencers
	always_ff @(posedge clock) begin
		if (reset125) begin
			astate       <= 2'b00;
			wstate       <= 2'b00;
			rstate       <= 2'b00;
			wword        <= LAST_HW;
			rword        <= LAST_HW;
			address_reg  <= '0;
			write_strobe <= 1'b0;
			pre_ack      <= 1'b0;
			ack_pipe     <= '0;
			errors       <= '0;
		end else begin
			pre_ack      <= 1'b0;
			write_strobe <= 1'b0;
			if (settled.active) begin
				if (settled.read_mode) begin
					pre_ack <= 1'b1;
					if (rstate == 2'b00) begin
						rstate <= 2'b01;
					end
				end else if (settled.write_mode_data) begin
					pre_ack <= 1'b1;
					if (wstate == 2'b00) begin
						wstate <= 2'b01;
					end
				end else if (settled.write_mode_address) begin
					pre_ack <= 1'b1;
					if (astate == 2'b00) begin
						astate <= 2'b01;
					end
				end
			end else if (settled.idle) begin
				if (rstate[1] || wstate[1]) begin
					address_reg <= address_reg + 1'b1; // autoincrement
				end
				if (wstate != 2'b00) begin
					if (read_partial) begin // abandon the read
						rstate             <= 2'b00;
						rword              <= LAST_HW;
						errors.read_errors <= errors.read_errors + 1'b1;
					end
					if (address_partial) begin
						astate                <= 2'b00;
						errors.address_errors <= errors.address_errors + 1'b1;
					end
					if (wstate[1]) begin
						wstate <= 2'b00;
						wword  <= LAST_HW;
					end else if (wword != '0) begin
						wstate <= 2'b00;
						wword  <= wword - 1'b1;
					end else begin
						wstate       <= 2'b10;
						write_strobe <= 1'b1; // word complete
					end
				end
				if (rstate != 2'b00) begin
					if (write_partial) begin // abandon the write
						wstate              <= 2'b00;
						wword               <= LAST_HW;
						errors.write_errors <= errors.write_errors + 1'b1;
					end
					if (address_partial) begin
						astate                <= 2'b00;
						errors.address_errors <= errors.address_errors + 1'b1;
					end
					if (rstate[1]) begin
						rstate <= 2'b00;
						rword  <= LAST_HW;
					end else if (rword != '0) begin
						rstate <= 2'b00;
						rword  <= rword - 1'b1;
					end else begin
						rstate <= 2'b10;
					end
				end
				if (astate != 2'b00) begin
					if (write_partial) begin
						wstate              <= 2'b00;
						wword               <= LAST_HW;
						errors.write_errors <= errors.write_errors + 1'b1;
					end
					if (read_partial) begin
						rstate             <= 2'b00;
						rword              <= LAST_HW;
						errors.read_errors <= errors.read_errors + 1'b1;
					end
					if (astate[1]) begin
						astate      <= 2'b00;
						address_reg <= address_word; // overrides the increment
					end else begin
						astate <= 2'b10;
					end
				end
			end
			ack_pipe <= {ack_pipe[`ACK_STAGES-2:0], pre_ack};
		end
	end

	assign ack_valid = ack_pipe[`ACK_STAGES-1];

	assign mem_write.address      = address_reg;
	assign mem_write.data         = write_data;
	assign mem_write.write_strobe = write_strobe;

endmodule

/* verilog/word_ram.sv */
/* no reset, contents start unknown
   both ports read with one cycle of latency, port a reads old data on a write */

`include "pollable_memory_defs.svh"

module word_ram (
	input  logic                          clock,
	input  mem_pkg::mem_write_t           mem_write,
	output mem_pkg::data_word_t           read_word,
	input  logic [`BYTE_ADDRESS_DEPTH-1:0] byte_address,
	output logic [7:0]                    read_byte
);
	import mem_pkg::*;

	localparam int WORDS = 2 ** `ADDRESS_DEPTH;

	data_word_t memory [WORDS];

	logic [`ADDRESS_DEPTH-1:0] word_select;
	logic [1:0]                lane;

	assign word_select = byte_address[`BYTE_ADDRESS_DEPTH-1:2];
	assign lane        = byte_address[1:0]; // lane 0 is the low byte

	// port a, 32 bit words
	always_ff @(posedge clock) begin
		if (mem_write.write_strobe) begin
			memory[mem_write.address] <= mem_write.data;
		end
		read_word <= memory[mem_write.address];
	end

	// port b, byte gearbox
	always_ff @(posedge clock) begin
		read_byte <= memory[word_select].bytes[lane];
	end

endmodule

/* verilog/playback_reader.sv */
/* loops over the playback region forever, never stalls
   sync marks the byte read from PLAYBACK_START */

`include "pollable_memory_defs.svh"

module playback_reader (
	input  logic                           clock,
	input  logic                           reset125,
	output logic [`BYTE_ADDRESS_DEPTH-1:0] byte_address,
	input  logic [7:0]                     read_byte,
	output mem_pkg::playback_t             playback
);
	localparam logic [`BYTE_ADDRESS_DEPTH-1:0] FIRST = `PLAYBACK_START;
	localparam logic [`BYTE_ADDRESS_DEPTH-1:0] LAST  =
		`PLAYBACK_START + `PLAYBACK_BYTES - 1;

	logic at_first;
	logic wrap_flag;

	assign at_first = (byte_address == FIRST);

	always_ff @(posedge clock) begin
		if (reset125) begin
			byte_address <= FIRST;
			wrap_flag    <= 1'b0;
		end else begin
			if (byte_address == LAST) begin
				byte_address <= FIRST; // wrap
			end else begin
				byte_address <= byte_address + 1'b1;
			end
			wrap_flag <= at_first; // matches the ram latency
		end
	end

	assign playback.data_byte = read_byte;
	assign playback.sync      = wrap_flag;

endmodule

/* verilog/pollable_memory_top.sv */
/* parallel bus slave with a pollable word memory and byte playback
   bus_oe follows the raw read line, bus_out is valid while ack_valid is high */

`include "pollable_memory_defs.svh"

module pollable_memory_top (
	input  logic                    clock,
	input  logic                    reset125,
	input  logic                    enable,
	input  logic                    read,
	input  logic                    register_select,
	input  logic [`BUS_WIDTH-1:0]   bus_in,
	output logic [`BUS_WIDTH-1:0]   bus_out,
	output logic                    bus_oe,
	output logic                    ack_valid,
	output bus_pkg::error_counts_t  errors,
	output mem_pkg::playback_t      playback
);
	import bus_pkg::*;
	import mem_pkg::*;

	bus_cmd_t                       cmd;
	bus_settled_t                   settled;
	logic [`BUS_WIDTH-1:0]          bus_data;
	mem_write_t                     mem_write;
	data_word_t                     read_word;
	logic [`BYTE_ADDRESS_DEPTH-1:0] byte_address;
	logic [7:0]                     read_byte;

	assign cmd.enable          = enable;
	assign cmd.read            = read;
	assign cmd.register_select = register_select;
	assign cmd.data            = bus_in;

	assign bus_oe = read; // slave drives only in read mode

	// ------------------------------
	bus_sync sync0 (
		.clock    (clock),
		.reset125 (reset125),
		.cmd      (cmd),
		.settled  (settled),
		.bus_data (bus_data)
	);

	bus_slave slave0 (
		.clock     (clock),
		.reset125  (reset125),
		.settled   (settled),
		.bus_data  (bus_data),
		.read_word (read_word),
		.mem_write (mem_write),
		.bus_out   (bus_out),
		.ack_valid (ack_valid),
		.errors    (errors)
	);

	// ------------------------------
	word_ram ram0 (
		.clock        (clock),
		.mem_write    (mem_write),
		.read_word    (read_word),
		.byte_address (byte_address),
		.read_byte    (read_byte)
	);

	playback_reader player0 (
		.clock        (clock),
		.reset125     (reset125),
		.byte_address (byte_address),
		.read_byte    (read_byte),
		.playback     (playback)
	);

endmodule

/* bench/pollable_memory_assertions.sv */
/* handshake and strobe checks on the bus slave, attached by bind
   bounds follow the sync and ack pipeline depths */

`include "pollable_memory_defs.svh"

module pollable_memory_assertions (
	input logic                  clock,
	input logic                  reset125,
	input bus_pkg::bus_settled_t settled,
	input mem_pkg::mem_write_t   mem_write,
	input logic                  ack_valid
);

	// ------------------------------
	ack_release: assert property (
		@(posedge clock) disable iff (reset125)
		$rose(settled.idle) |-> ##(`ACK_STAGES + 1) !ack_valid
	) else $error("ack_valid still high %0d cycles after idle settled", `ACK_STAGES + 1);

	strobe_single: assert property (
		@(posedge clock) disable iff (reset125)
		mem_write.write_strobe |=> !mem_write.write_strobe
	) else $error("write_strobe held longer than one cycle");

	// no ack can leave the sync and ack pipelines this early
	ack_after_reset: assert property (
		@(posedge clock)
		$fell(reset125) |-> !ack_valid ##(`SYNC_STAGES + `ACK_STAGES + 1) !ack_valid
	) else $error("ack_valid high soon after reset is released");

endmodule

bind bus_slave pollable_memory_assertions assertions0 (
	.clock     (clock),
	.reset125  (reset125),
	.settled   (settled),
	.mem_write (mem_write),
	.ack_valid (ack_valid)
);

/* bench/pollable_memory_tb.sv */
/* reads only words written earlier in the run
   watchdog bound scales with TRANSFERS and PASSES */

`include "pollable_memory_defs.svh"

module pollable_memory_tb;
	import bus_pkg::*;
	import mem_pkg::*;

	localparam int WRITE_ADDRESS   = 0;
	localparam int WRITE_DATA      = 1;
	localparam int READ_HALF       = 2;
	localparam int BYTE_BITS       = `BYTE_ADDRESS_DEPTH;
	localparam int TRANSFERS       = 48; // host transactions over all tests
	localparam int PASSES          = 3;  // playback passes checked
	localparam int WATCHDOG_CYCLES = 64 * TRANSFERS + (PASSES + 2) * `PLAYBACK_BYTES + 64;

	logic                  clock;
	logic                  reset125;
	logic                  enable;
	logic                  read;
	logic                  register_select;
	logic [`BUS_WIDTH-1:0] bus_in;
	logic [`BUS_WIDTH-1:0] bus_out;
	logic                  bus_oe;
	logic                  ack_valid;
	error_counts_t         errors;
	playback_t             playback;

	// reference model state
	logic [31:0]                   model_mem [2 ** `ADDRESS_DEPTH];
	logic [31:0]                   model_wbuf;
	logic [`ADDRESS_DEPTH-1:0]     model_addr;
	int                            model_whalf; // halfwords held
	int                            model_rhalf;
	logic [`ERROR_COUNT_WIDTH-1:0] model_read_errors;
	logic [`ERROR_COUNT_WIDTH-1:0] model_write_errors;

	logic [`BUS_WIDTH-1:0] expect_q[$];
	logic [`BUS_WIDTH-1:0] got_q[$];
	logic [`BUS_WIDTH-1:0] expect_half;
	logic [`BUS_WIDTH-1:0] got_half;
	logic [7:0]            expect_byte;
	logic                  pb_enable;
	int                    pb_pos; // -1 until the first sync
	int                    check_count;
	int                    fail_count;
	int                    fails_before;
	logic [31:0]           rng;

	pollable_memory_top dut0 (
		.clock           (clock),
		.reset125        (reset125),
		.enable          (enable),
		.read            (read),
		.register_select (register_select),
		.bus_in          (bus_in),
		.bus_out         (bus_out),
		.bus_oe          (bus_oe),
		.ack_valid       (ack_valid),
		.errors          (errors),
		.playback        (playback)
	);

	always #20 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ------------------------------
	// reference model of one host transaction
	function automatic logic [`BUS_WIDTH-1:0] model_transfer(input int kind,
			input logic [`BUS_WIDTH-1:0] data);
		logic [`BUS_WIDTH-1:0] result;
		int lane;
		result = '0;
		if (kind != READ_HALF && model_rhalf != 0) begin // partial read dropped
			model_read_errors = model_read_errors + 1'b1;
			model_rhalf = 0;
		end
		if (kind != WRITE_DATA && model_whalf != 0) begin
			model_write_errors = model_write_errors + 1'b1;
			model_whalf = 0;
		end
		if (kind == WRITE_ADDRESS) begin
			model_addr = data[`ADDRESS_DEPTH-1:0];
		end else if (kind == WRITE_DATA) begin
			lane = `HALFWORDS_PER_WORD - 1 - model_whalf; // msb halfword first
			model_wbuf[lane*`BUS_WIDTH +: `BUS_WIDTH] = data;
			model_whalf++;
			if (model_whalf == `HALFWORDS_PER_WORD) begin
				model_mem[model_addr] = model_wbuf;
				model_addr = model_addr + 1'b1;
				model_whalf = 0;
			end
		end else begin
			lane = `HALFWORDS_PER_WORD - 1 - model_rhalf;
			result = model_mem[model_addr][lane*`BUS_WIDTH +: `BUS_WIDTH];
			model_rhalf++;
			if (model_rhalf == `HALFWORDS_PER_WORD) begin
				model_addr = model_addr + 1'b1;
				model_rhalf = 0;
			end
		end
		return result;
	endfunction

	function automatic logic [7:0] model_byte(input int pos);
		logic [`BYTE_ADDRESS_DEPTH-1:0] ba;
		ba = BYTE_BITS'(`PLAYBACK_START + pos);
		return model_mem[ba[`BYTE_ADDRESS_DEPTH-1:2]][ba[1:0]*8 +: 8]; // lsb first
	endfunction

	// ------------------------------
	task automatic wait_ack(input logic level);
		do begin
			@(posedge clock);
		end while (ack_valid !== level);
	endtask

	task automatic host_transfer(input int kind, input logic [`BUS_WIDTH-1:0] data);
		logic [`BUS_WIDTH-1:0] expected;
		logic [`BUS_WIDTH-1:0] sampled;
		expected = model_transfer(kind, data);
		@(posedge clock);
		read            <= (kind == READ_HALF);
		register_select <= (kind != WRITE_ADDRESS);
		bus_in          <= data;
		@(posedge clock);
		enable <= 1'b1;
		wait_ack(1'b1);
		sampled = bus_out; // valid while ack_valid is high
		check_count++;
		if (bus_oe !== (kind == READ_HALF)) begin
			$display("FAILED bus_oe: expected %h, got %h", kind == READ_HALF, bus_oe);
			fail_count++;
		end
		enable <= 1'b0;
		wait_ack(1'b0);
		read <= 1'b0;
		repeat (`SYNC_STAGES + 4) @(posedge clock);
		if (kind == READ_HALF) begin
			expect_q.push_back(expected);
			got_q.push_back(sampled);
		end
	endtask

	task automatic drain_reads();
		while (got_q.size() != 0) @(posedge clock);
	endtask

	task automatic check_errors();
		check_count += 3;
		if (errors.read_errors !== model_read_errors) begin
			$display("FAILED errors.read_errors: expected %h, got %h",
				model_read_errors, errors.read_errors);
			fail_count++;
		end
		if (errors.write_errors !== model_write_errors) begin
			$display("FAILED errors.write_errors: expected %h, got %h",
				model_write_errors, errors.write_errors);
			fail_count++;
		end
		if (errors.address_errors !== '0) begin
			$display("FAILED errors.address_errors: expected 00, got %h", errors.address_errors);
			fail_count++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d failures", name, fail_count - fails_before);
		fails_before = fail_count;
	endtask

	// ------------------------------
	// compare process for read halfwords and playback bytes
	always @(posedge clock) begin
		if (got_q.size() != 0) begin
			expect_half = expect_q.pop_front();
			got_half    = got_q.pop_front();
			check_count++;
			if (got_half !== expect_half) begin
				$display("FAILED bus_out: expected %h, got %h", expect_half, got_half);
				fail_count++;
			end
		end
		if (pb_enable) begin
			if (pb_pos < 0 && playback.sync) begin
				pb_pos = 0;
			end
			if (pb_pos >= 0) begin
				expect_byte = model_byte(pb_pos % `PLAYBACK_BYTES);
				check_count += 2;
				if (playback.sync !== (pb_pos % `PLAYBACK_BYTES == 0)) begin
					$display("FAILED playback.sync: expected %h, got %h",
						pb_pos % `PLAYBACK_BYTES == 0, playback.sync);
					fail_count++;
				end
				if (playback.data_byte !== expect_byte) begin
					$display("FAILED playback.data_byte: expected %h, got %h",
						expect_byte, playback.data_byte);
					fail_count++;
				end
				pb_pos++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		clock              = 1'b0;
		reset125           = 1'b1;
		enable             = 1'b0;
		read               = 1'b0;
		register_select    = 1'b0;
		bus_in             = '0;
		rng                = 32'd18;
		pb_enable          = 1'b0;
		pb_pos             = -1;
		check_count        = 0;
		fail_count         = 0;
		fails_before       = 0;
		model_addr         = '0;
		model_whalf        = 0;
		model_rhalf        = 0;
		model_read_errors  = '0;
		model_write_errors = '0;
		repeat (4) @(posedge clock);
		reset125 <= 1'b0;

		repeat (8) @(posedge clock); // no host activity
		check_count += 2;
		if (ack_valid !== 1'b0) begin
			$display("FAILED ack_valid: expected 0, got %h", ack_valid);
			fail_count++;
		end
		if (bus_oe !== 1'b0) begin
			$display("FAILED bus_oe: expected 0, got %h", bus_oe);
			fail_count++;
		end
		check_errors();
		report_test("reset state");

		host_transfer(WRITE_ADDRESS, '0);
		for (int i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			host_transfer(WRITE_DATA, rng[31:16]);
			host_transfer(WRITE_DATA, rng[15:0]);
		end
		host_transfer(WRITE_ADDRESS, '0);
		for (int i = 0; i < 16; i++) begin
			host_transfer(READ_HALF, '0);
		end
		drain_reads();
		check_errors();
		report_test("write and read back with autoincrement");

		pb_pos    = -1;
		pb_enable = 1'b1;
		while (pb_pos < PASSES * `PLAYBACK_BYTES) @(posedge clock);
		pb_enable = 1'b0;
		report_test("playback bytes");

		rng = xorshift(rng);
		host_transfer(WRITE_DATA, rng[15:0]); // lone halfword
		host_transfer(WRITE_ADDRESS, 16'h0040);
		rng = xorshift(rng);
		host_transfer(WRITE_DATA, rng[31:16]);
		host_transfer(WRITE_DATA, rng[15:0]);
		host_transfer(WRITE_ADDRESS, 16'h0040);
		host_transfer(READ_HALF, '0);
		host_transfer(READ_HALF, '0);
		drain_reads();
		check_errors();
		report_test("partial write abandoned by address");

		host_transfer(WRITE_ADDRESS, 16'h0005);
		host_transfer(READ_HALF, '0); // lone read halfword
		rng = xorshift(rng);
		host_transfer(WRITE_DATA, rng[31:16]);
		host_transfer(WRITE_DATA, rng[15:0]);
		host_transfer(WRITE_ADDRESS, 16'h0005);
		host_transfer(READ_HALF, '0);
		host_transfer(READ_HALF, '0);
		drain_reads();
		check_errors();
		report_test("partial read abandoned by write");

		$display("%0d checks, %0d failures", check_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+verilog
verilog/bus_pkg.sv
verilog/mem_pkg.sv
verilog/bus_sync.sv
verilog/bus_slave.sv
verilog/word_ram.sv
verilog/playback_reader.sv
verilog/pollable_memory_top.sv
bench/pollable_memory_assertions.sv
bench/pollable_memory_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
verilator --binary --assert -Wno-fatal -f tb.f --top-module pollable_memory_tb -o pollable_memory_sim \
	&& ./obj_dir/pollable_memory_sim | tee /dev/stderr | grep -q "All tests passed!" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
